/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = cpuTb
FILELIST = cpu.f

OBJDIR = obj_dir
BIN = $(OBJDIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* cpu.f */
verilog/cpuPkg.sv
verilog/pipeReg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/hazardUnit.sv
verilog/dataMemory.sv
verilog/cpu.sv
test/cpu_properties.sv
test/cpuTb.sv

/* test/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	localparam int progLen = 25;
	localparam int resetCycles = 8;
	localparam int quietCycles = 20; // Watch for stray commits after the last one
	// Budget per row, load time, reset and margin
	localparam int timeoutCycles = progLen * 6 + progLen + resetCycles + 50;

	// One program row per instruction
	typedef struct packed {
		logic [3:0] op;
		regAddr_t rd;
		regAddr_t rs1;
		regAddr_t rs2;
		logic [11:0] imm;
		logic rndImm; // Immediate drawn from $urandom
	} row_t;

	logic clock;
	logic rst;
	logic progWe;
	logic [memAddrWidth-1:0] progAddr;
	word_t progData;
	logic wbValid;
	regAddr_t wbAddr;
	word_t wbData;

	regAddr_t expAddr [$];
	word_t expData [$];
	int commitCount = 0;

	// op, rd, rs1, rs2, imm, random imm
	row_t progTable [progLen] = '{
		'{opAddi, 4'd1, 4'd0, 4'd0, 12'h000, 1'b1},
		'{opAddi, 4'd2, 4'd0, 4'd0, 12'h000, 1'b1},
		'{opAdd, 4'd3, 4'd1, 4'd2, 12'h000, 1'b0}, // r2 from memory stage, r1 from write-back
		'{opSub, 4'd4, 4'd3, 4'd1, 12'h000, 1'b0},
		'{opXor, 4'd5, 4'd4, 4'd3, 12'h000, 1'b0},
		'{opAnd, 4'd6, 4'd5, 4'd2, 12'h000, 1'b0},
		'{opOrr, 4'd7, 4'd6, 4'd5, 12'h000, 1'b0},
		'{opAddi, 4'd8, 4'd0, 4'd0, 12'd20, 1'b0}, // Base address
		'{opStr, 4'd7, 4'd8, 4'd0, 12'h000, 1'b0},
		'{opLdr, 4'd9, 4'd8, 4'd0, 12'h000, 1'b0},
		'{opAdd, 4'd10, 4'd9, 4'd1, 12'h000, 1'b0}, // Load-use on rs1
		'{opLdr, 4'd11, 4'd8, 4'd0, 12'h000, 1'b0},
		'{opStr, 4'd11, 4'd8, 4'd0, 12'h001, 1'b0}, // Load-use on store data
		'{opLdr, 4'd12, 4'd8, 4'd0, 12'h001, 1'b0},
		'{opAddi, 4'd0, 4'd1, 4'd0, 12'h005, 1'b0}, // Write to r0, silent
		'{opAdd, 4'd13, 4'd0, 4'd2, 12'h000, 1'b0}, // r0 reads zero
		'{opBeq, 4'd2, 4'd13, 4'd0, 12'h002, 1'b0}, // Taken, skips two rows
		'{opAddi, 4'd14, 4'd0, 4'd0, 12'h001, 1'b0},
		'{opAddi, 4'd15, 4'd0, 4'd0, 12'h002, 1'b0},
		'{opBne, 4'd3, 4'd3, 4'd0, 12'h001, 1'b0}, // Not taken
		'{opAddi, 4'd14, 4'd0, 4'd0, 12'h007, 1'b0},
		'{4'd12, 4'd5, 4'd1, 4'd2, 12'h000, 1'b0}, // Undefined opcodes
		'{4'd15, 4'd6, 4'd2, 4'd3, 12'h000, 1'b0},
		'{opAdd, 4'd15, 4'd14, 4'd13, 12'h000, 1'b0},
		'{opSub, 4'd1, 4'd15, 4'd12, 12'h000, 1'b0}
	};

	cpu i_cpu (
		.clock(clock), .rst(rst),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	function automatic word_t encodeInstr(input row_t row);
		return {row.op, row.rd, row.rs1, row.imm | {row.rs2, 8'h00}}; // rs2 overlaps imm
	endfunction

	function automatic word_t signExtend(input logic [11:0] imm);
		return {{12{imm[11]}}, imm};
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkReg(input string name, input regAddr_t got, input regAddr_t exp);
		if (got !== exp) begin
			failRun($sformatf("CHECK FAILED: %s = 0x%0h, expected 0x%0h at commit %0d",
				name, got, exp, commitCount));
		end
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			failRun($sformatf("CHECK FAILED: %s = 0x%0h, expected 0x%0h at commit %0d",
				name, got, exp, commitCount));
		end
	endtask

	// In-order ISA model, one row per step
	task automatic buildExpected();
		word_t regs [regCount];
		word_t dmem [memDepth];
		word_t a, b, d, imm, res, addr, pc, next;
		logic writes;
		int steps;
		row_t row;
		for (int i = 0; i < regCount; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < memDepth; i++) begin
			dmem[i] = '0;
		end
		pc = '0;
		steps = 0;
		while (pc < progLen && steps < progLen * 4) begin // Rows past the end are no-ops
			row = progTable[pc];
			a = regs[row.rs1];
			b = regs[row.rs2];
			d = regs[row.rd]; // Store data and branch operand
			imm = signExtend(row.imm);
			addr = a + imm;
			next = pc + 1;
			writes = 1'b0;
			res = '0;
			case (row.op)
				opAdd: begin res = a + b; writes = 1'b1; end
				opSub: begin res = a - b; writes = 1'b1; end
				opAnd: begin res = a & b; writes = 1'b1; end
				opOrr: begin res = a | b; writes = 1'b1; end
				opXor: begin res = a ^ b; writes = 1'b1; end
				opAddi: begin res = a + imm; writes = 1'b1; end
				opLdr: begin res = dmem[addr[memAddrWidth-1:0]]; writes = 1'b1; end
				opStr: dmem[addr[memAddrWidth-1:0]] = d;
				opBeq: if (a == d) next = pc + 1 + imm;
				opBne: if (a != d) next = pc + 1 + imm;
				default: ; // Nothing happens
			endcase
			if (writes && row.rd != '0) begin
				regs[row.rd] = res;
				expAddr.push_back(row.rd);
				expData.push_back(res);
			end
			pc = next;
			steps++;
		end
	endtask

	// Commits sampled mid-cycle, away from the edge
	always @(negedge clock) begin
		if (!rst && wbValid) begin
			if (commitCount < expAddr.size()) begin // Extras only counted here
				checkReg("wbAddr", wbAddr, expAddr[commitCount]);
				checkWord("wbData", wbData, expData[commitCount]);
			end
			commitCount++;
		end
	end

	initial begin
		repeat (timeoutCycles) @(posedge clock);
		failRun("Timeout, the commits never completed");
	end

	initial begin
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		void'($urandom(71));
		for (int i = 0; i < progLen; i++) begin
			if (progTable[i].rndImm) begin
				progTable[i].imm = 12'($urandom());
			end
		end
		buildExpected();
		@(posedge clock);
		#2;
		// Program load while rst is high
		for (int i = 0; i < progLen; i++) begin
			progWe = 1'b1;
			progAddr = memAddrWidth'(i);
			progData = encodeInstr(progTable[i]);
			@(posedge clock);
			#2;
		end
		progWe = 1'b0;
		repeat (resetCycles) @(posedge clock); // Then the reset proper
		#2;
		rst = 1'b0;
		wait (commitCount == expAddr.size());
		repeat (quietCycles) @(negedge clock);
		if (commitCount == expAddr.size()) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			failRun($sformatf("Commit count %0d, expected %0d", commitCount, expAddr.size()));
		end
	end

endmodule

/* test/cpu_properties.sv */
`timescale 1ns/1ps

module cpuProperties (
	input logic clock,
	input logic rst,
	input logic wbValid,
	input cpuPkg::word_t wbData,
	input logic branchTaken,
	input cpuPkg::fetchToDecode_t decodeSlot,
	input cpuPkg::decodeToExec_t execSlot
);

	// Held reset keeps the commit port quiet
	resetQuiet: assert property (@(posedge clock) (rst && $past(rst)) |-> !wbValid)
		else $error("wbValid high during reset");

	dataKnown: assert property (@(posedge clock) disable iff (rst)
		wbValid |-> !$isunknown(wbData))
		else $error("Commit data has unknown bits");

	// Taken branch leaves bubbles in decode and execute
	branchFlush: assert property (@(posedge clock) disable iff (rst)
		branchTaken |=> (decodeSlot == '0) && (execSlot == '0))
		else $error("Taken branch did not clear decode and execute");

endmodule

bind cpu cpuProperties i_cpuProperties (
	.clock(clock),
	.rst(rst),
	.wbValid(wbValid),
	.wbData(wbData),
	.branchTaken(branchTaken),
	.decodeSlot(fetchD),
	.execSlot(decodeE)
);

/* verilog/cpu.sv */
`timescale 1ns/1ps

module cpu (
	input logic clock,
	input logic rst,
	input logic progWe,
	input logic [cpuPkg::memAddrWidth-1:0] progAddr,
	input cpuPkg::word_t progData,
	output logic wbValid,
	output cpuPkg::regAddr_t wbAddr,
	output cpuPkg::word_t wbData
);
	import cpuPkg::*;

	fetchToDecode_t fetchF, fetchD;
	decodeToExec_t decodeD, decodeE;
	execToMem_t execE, execM;
	memToWb_t memM, memWb;

	logic branchTaken;
	word_t branchTarget;
	logic [1:0] fwdSelA, fwdSelB;
	logic stallFetch, stallDecode, flushDecode, flushExec;
	word_t loadData;
	word_t wbResult;

	fetchStage u_fetch (
		.clock(clock), .rst(rst),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.stall(stallFetch),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.fetchOut(fetchF)
	);

	// Flush wins over stall inside pipeReg
	pipeReg #(.payload_t(fetchToDecode_t)) u_regDecode (
		.clock(clock), .rst(rst), .enable(!stallDecode), .clear(flushDecode),
		.d(fetchF), .q(fetchD)
	);

	decodeStage u_decode (
		.clock(clock), .rst(rst),
		.fetchIn(fetchD),
		.wbWrite(memWb.regWrite), .wbAddr(memWb.rd), .wbData(wbResult),
		.decodeOut(decodeD)
	);

	// Bubble inserted here on load-use or taken branch
	pipeReg #(.payload_t(decodeToExec_t)) u_regExec (
		.clock(clock), .rst(rst), .enable(1'b1), .clear(flushExec),
		.d(decodeD), .q(decodeE)
	);

	executeStage u_execute (
		.execIn(decodeE),
		.memResult(execM.aluResult), .wbResult(wbResult),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
		.execOut(execE),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	pipeReg #(.payload_t(execToMem_t)) u_regMem (
		.clock(clock), .rst(rst), .enable(1'b1), .clear(1'b0),
		.d(execE), .q(execM)
	);

	dataMemory u_dataMem (
		.clock(clock),
		.writeEnable(execM.memWrite),
		.address(execM.aluResult),
		.writeData(execM.storeData),
		.readData(loadData)
	);

	assign memM.aluResult = execM.aluResult;
	assign memM.loadData = loadData;
	assign memM.rd = execM.rd;
	assign memM.regWrite = execM.regWrite;
	assign memM.memToReg = execM.memToReg;

	pipeReg #(.payload_t(memToWb_t)) u_regWb (
		.clock(clock), .rst(rst), .enable(1'b1), .clear(1'b0),
		.d(memM), .q(memWb)
	);

	assign wbResult = memWb.memToReg ? memWb.loadData : memWb.aluResult; // Write-back mux

	// Commit port, r0 writes are silent
	assign wbValid = memWb.regWrite && (memWb.rd != '0);
	assign wbAddr = memWb.rd;
	assign wbData = wbResult;

	hazardUnit u_hazard (
		.rs1Decode(decodeD.rs1), .rs2Decode(decodeD.rs2),
		.rs1Exec(decodeE.rs1), .rs2Exec(decodeE.rs2),
		.rdExec(decodeE.rd), .memToRegExec(decodeE.memToReg),
		.rdMem(execM.rd), .regWriteMem(execM.regWrite),
		.rdWb(memWb.rd), .regWriteWb(memWb.regWrite),
		.branchTaken(branchTaken),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
		.stallFetch(stallFetch), .stallDecode(stallDecode),
		.flushDecode(flushDecode), .flushExec(flushExec)
	);

endmodule

/* verilog/cpuPkg.sv */
package cpuPkg;

	// Datapath and storage sizes
	localparam int dataWidth = 24;
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;
	localparam int opcodeWidth = 4;
	localparam int immWidth = 12; // Low instruction bits, overlaps rs2
	localparam int memDepth = 256;
	localparam int memAddrWidth = 8; // Low address bits index both RAMs

	// Forwarding mux selects
	localparam logic [1:0] fwdReg = 2'd0; // Value read in decode
	localparam logic [1:0] fwdWb = 2'd1;
	localparam logic [1:0] fwdMem = 2'd2; // Youngest result wins

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	typedef enum logic [opcodeWidth-1:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOrr = 4'd3,
		opXor = 4'd4,
		opAddi = 4'd5,
		opLdr = 4'd6,
		opStr = 4'd7,
		opBeq = 4'd8,
		opBne = 4'd9 // 10 to 15 decode as no-ops
	} opcode_t;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluXor = 3'd4
	} aluOp_t;

	typedef struct packed {
		logic negative;
		logic zero;
		logic carry; // No borrow on subtract
		logic overflow;
	} flags_t;

	typedef struct packed {
		word_t instr;
		word_t pcPlus1;
	} fetchToDecode_t;

	// All zeros is a bubble: no register, memory or branch effect
	typedef struct packed {
		word_t regA;
		word_t regB; // Store data or compare operand
		word_t imm;
		word_t pcPlus1;
		regAddr_t rd;
		regAddr_t rs1;
		regAddr_t rs2; // Second source, rd field for STR and branches
		logic regWrite;
		logic memWrite;
		logic memToReg;
		logic useImm;
		aluOp_t aluOp;
		logic isBranch;
		logic branchOnEqual;
	} decodeToExec_t;

	typedef struct packed {
		word_t aluResult;
		word_t storeData;
		regAddr_t rd;
		logic regWrite;
		logic memWrite;
		logic memToReg;
	} execToMem_t;

	typedef struct packed {
		word_t aluResult;
		word_t loadData;
		regAddr_t rd;
		logic regWrite;
		logic memToReg;
	} memToWb_t;

endpackage

/* verilog/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
	input logic clock,
	input logic writeEnable,
	input cpuPkg::word_t address,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t readData
);
	import cpuPkg::*;

	word_t mem [memDepth];

	initial begin
		for (int i = 0; i < memDepth; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clock) begin
		if (writeEnable) begin
			mem[address[memAddrWidth-1:0]] <= writeData; // Upper address bits ignored
		end
	end

	assign readData = mem[address[memAddrWidth-1:0]]; // Async read

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input logic clock,
	input logic rst,
	input cpuPkg::fetchToDecode_t fetchIn,
	input logic wbWrite,
	input cpuPkg::regAddr_t wbAddr,
	input cpuPkg::word_t wbData,
	output cpuPkg::decodeToExec_t decodeOut
);
	import cpuPkg::*;

	word_t regs [regCount];
	opcode_t opcode;
	regAddr_t rdField, rs1Field, rs2Field;
	regAddr_t src2;
	word_t imm;
	logic regWrite, memWrite, memToReg, useImm, isBranch, branchOnEqual;
	aluOp_t aluOp;

	// Instruction fields
	assign opcode = opcode_t'(fetchIn.instr[23:20]);
	assign rdField = fetchIn.instr[19:16];
	assign rs1Field = fetchIn.instr[15:12];
	assign rs2Field = fetchIn.instr[11:8]; // Shares bits with imm
	assign imm = {{(dataWidth-immWidth){fetchIn.instr[immWidth-1]}},
		fetchIn.instr[immWidth-1:0]};

	// Main decoder
	always_comb begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		useImm = 1'b0;
		isBranch = 1'b0;
		branchOnEqual = 1'b0;
		aluOp = aluAdd;
		src2 = '0; // Unused source never matches a hazard
		case (opcode)
			opAdd: begin regWrite = 1'b1; src2 = rs2Field; end
			opSub: begin regWrite = 1'b1; aluOp = aluSub; src2 = rs2Field; end
			opAnd: begin regWrite = 1'b1; aluOp = aluAnd; src2 = rs2Field; end
			opOrr: begin regWrite = 1'b1; aluOp = aluOr; src2 = rs2Field; end
			opXor: begin regWrite = 1'b1; aluOp = aluXor; src2 = rs2Field; end
			opAddi: begin regWrite = 1'b1; useImm = 1'b1; end
			opLdr: begin regWrite = 1'b1; memToReg = 1'b1; useImm = 1'b1; end
			opStr: begin memWrite = 1'b1; useImm = 1'b1; src2 = rdField; end // Store data in rd
			opBeq: begin isBranch = 1'b1; branchOnEqual = 1'b1; aluOp = aluSub; src2 = rdField; end
			opBne: begin isBranch = 1'b1; aluOp = aluSub; src2 = rdField; end
			default: ; // Undefined opcodes stay a bubble
		endcase
	end

	// Register file, r0 never written
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Read with same-cycle write-through
	function automatic word_t readReg(input regAddr_t addr);
		if (addr == '0) return '0;
		if (wbWrite && wbAddr == addr) return wbData;
		return regs[addr];
	endfunction

	always_comb begin
		decodeOut.regA = readReg(rs1Field);
		decodeOut.regB = readReg(src2);
	end

	assign decodeOut.imm = imm;
	assign decodeOut.pcPlus1 = fetchIn.pcPlus1;
	assign decodeOut.rd = regWrite ? rdField : '0; // No destination when nothing is written
	assign decodeOut.rs1 = rs1Field;
	assign decodeOut.rs2 = src2;
	assign decodeOut.regWrite = regWrite;
	assign decodeOut.memWrite = memWrite;
	assign decodeOut.memToReg = memToReg;
	assign decodeOut.useImm = useImm;
	assign decodeOut.aluOp = aluOp;
	assign decodeOut.isBranch = isBranch;
	assign decodeOut.branchOnEqual = branchOnEqual;

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input cpuPkg::decodeToExec_t execIn,
	input cpuPkg::word_t memResult,
	input cpuPkg::word_t wbResult,
	input logic [1:0] fwdSelA,
	input logic [1:0] fwdSelB,
	output cpuPkg::execToMem_t execOut,
	output logic branchTaken,
	output cpuPkg::word_t branchTarget
);
	import cpuPkg::*;

	word_t srcA, fwdB, srcB;
	word_t bEff; // Operand as the adder sees it
	logic [dataWidth:0] sum; // Extra bit is carry out
	logic isArith;
	flags_t flags;

	function automatic word_t pickOperand(input logic [1:0] sel, input word_t regVal,
		input word_t memVal, input word_t wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = pickOperand(fwdSelA, execIn.regA, memResult, wbResult);
	assign fwdB = pickOperand(fwdSelB, execIn.regB, memResult, wbResult);
	assign srcB = execIn.useImm ? execIn.imm : fwdB; // ADDI, LDR, STR

	assign isArith = (execIn.aluOp == aluAdd) || (execIn.aluOp == aluSub);
	assign bEff = (execIn.aluOp == aluSub) ? ~srcB : srcB;

	// ALU
	always_comb begin
		case (execIn.aluOp)
			aluAdd: sum = {1'b0, srcA} + {1'b0, srcB};
			aluSub: sum = {1'b0, srcA} + {1'b0, bEff} + {{dataWidth{1'b0}}, 1'b1};
			aluAnd: sum = {1'b0, srcA & srcB};
			aluOr: sum = {1'b0, srcA | srcB};
			aluXor: sum = {1'b0, srcA ^ srcB};
			default: sum = '0;
		endcase
	end

	assign flags.negative = sum[dataWidth-1];
	assign flags.zero = (sum[dataWidth-1:0] == '0);
	assign flags.carry = isArith & sum[dataWidth];
	// Same operand signs, result sign differs
	assign flags.overflow = isArith & (srcA[dataWidth-1] == bEff[dataWidth-1])
		& (sum[dataWidth-1] != srcA[dataWidth-1]);

	// Branch compares its own operands only
	assign branchTaken = execIn.isBranch && (flags.zero == execIn.branchOnEqual);
	assign branchTarget = execIn.pcPlus1 + execIn.imm;

	assign execOut.aluResult = sum[dataWidth-1:0];
	assign execOut.storeData = fwdB;
	assign execOut.rd = execIn.rd;
	assign execOut.regWrite = execIn.regWrite;
	assign execOut.memWrite = execIn.memWrite;
	assign execOut.memToReg = execIn.memToReg;

endmodule

/* verilog/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
	input logic clock,
	input logic rst,
	input logic progWe,
	input logic [cpuPkg::memAddrWidth-1:0] progAddr,
	input cpuPkg::word_t progData,
	input logic stall,
	input logic branchTaken,
	input cpuPkg::word_t branchTarget,
	output cpuPkg::fetchToDecode_t fetchOut
);
	import cpuPkg::*;

	word_t pc;
	word_t instrMem [memDepth];

	// Empty words decode as ADD r0, which commits nothing
	initial begin
		for (int i = 0; i < memDepth; i++) begin
			instrMem[i] = '0;
		end
	end

	// Program load port, live only under reset
	always @(posedge clock) begin
		if (rst && progWe) begin
			instrMem[progAddr] <= progData;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
		end else if (branchTaken) begin // Redirect beats stall
			pc <= branchTarget;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	assign fetchOut.instr = instrMem[pc[memAddrWidth-1:0]]; // Async read, word addressed
	assign fetchOut.pcPlus1 = pc + 1'b1;

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	input cpuPkg::regAddr_t rs1Decode,
	input cpuPkg::regAddr_t rs2Decode,
	input cpuPkg::regAddr_t rs1Exec,
	input cpuPkg::regAddr_t rs2Exec,
	input cpuPkg::regAddr_t rdExec,
	input logic memToRegExec,
	input cpuPkg::regAddr_t rdMem,
	input logic regWriteMem,
	input cpuPkg::regAddr_t rdWb,
	input logic regWriteWb,
	input logic branchTaken,
	output logic [1:0] fwdSelA,
	output logic [1:0] fwdSelB,
	output logic stallFetch,
	output logic stallDecode,
	output logic flushDecode,
	output logic flushExec
);
	import cpuPkg::*;

	logic loadUse;

	// Memory stage first, r0 never forwarded
	function automatic logic [1:0] forwardFor(input regAddr_t src);
		if (src == '0) return fwdReg;
		if (regWriteMem && rdMem == src) return fwdMem;
		if (regWriteWb && rdWb == src) return fwdWb;
		return fwdReg;
	endfunction

	always_comb begin
		fwdSelA = forwardFor(rs1Exec);
		fwdSelB = forwardFor(rs2Exec);
	end

	// Load in execute feeding the instruction in decode
	assign loadUse = memToRegExec && (rdExec != '0) &&
		((rdExec == rs1Decode) || (rdExec == rs2Decode));

	assign stallFetch = loadUse;
	assign stallDecode = loadUse;
	assign flushDecode = branchTaken; // Kills the two younger instructions
	assign flushExec = branchTaken || loadUse;

endmodule

/* verilog/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic rst,
	input logic enable,
	input logic clear,
	input payload_t d,
	output payload_t q
);

	// Zero payload is a bubble, clear overrides a held stage
	always_ff @(posedge clock) begin
		if (rst || clear) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

endmodule
